//--- Makefile
# Verilator build and run of the coefficient sampler testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= abr_sampler_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build directory and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "result: passed"; \
	else \
		echo "result: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/abr_ctrl_pkg.sv
/*
 * abr control types
 * state encoding of the sampler run controller
 */

package abr_ctrl_pkg;

  // idle waits for start, run collects coefficients
  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } ctrl_state_e;

endpackage

//--- common/abr_data_pkg.sv
/*
 * abr data types
 * vector typedefs for the datapath of the coefficient sampler
 */

`include "abr_sampler_cfg.svh"

package abr_data_pkg;

  // one full sponge rate block from the hash engine
  typedef logic [`ABR_PISO_INPUT_RATE-1:0] blk_t;

  // one word leaving the shift buffer
  typedef logic [`ABR_PISO_OUTPUT_RATE-1:0] word_t;

  // candidate before the bound check, coefficient after it
  typedef logic [`ABR_CAND_W-1:0] cand_t;
  typedef logic [`ABR_CAND_W-1:0] coeff_t;

  // position of a coefficient within a run
  typedef logic [$clog2(`ABR_NUM_COEFF)-1:0] coeff_idx_t;

endpackage

//--- common/abr_sampler_cfg.svh
/*
 * abr sampler configuration
 * geometry of the shift buffer, candidate slicing, rejection bound
 * and the number of coefficients collected per run
 */

`ifndef ABR_SAMPLER_CFG_SVH
`define ABR_SAMPLER_CFG_SVH

// shift buffer geometry
`define ABR_PISO_BUFFER_W    1344
`define ABR_PISO_INPUT_RATE  1088
`define ABR_PISO_OUTPUT_RATE 80

// candidate slicing of one output word
`define ABR_CAND_W           20
`define ABR_CAND_PER_WORD    4

// candidates below this bound are accepted
`define ABR_REJ_Q            786433

// accepted coefficients per run
`define ABR_NUM_COEFF        256

`endif

//--- flist.f
+incdir+common
common/abr_data_pkg.sv
common/abr_ctrl_pkg.sv
hdl/abr_piso.sv
hdl/abr_rej_sampler.sv
hdl/abr_sampler_ctrl.sv
hdl/abr_sampler_top.sv
tests/abr_sampler_tb.sv

//--- hdl/abr_piso.sv
/*
 * abr_piso
 * parallel-in serial-out shift buffer, takes wide rate blocks and
 * hands them out as narrow words, LSB first
 * a block is accepted only when the whole block fits behind the
 * stored bits; read and write may share a cycle
 */

`timescale 1ns/1ps

`include "abr_sampler_cfg.svh"

module abr_piso #(
  parameter int PISO_BUFFER_W    = `ABR_PISO_BUFFER_W,
  parameter int PISO_INPUT_RATE  = `ABR_PISO_INPUT_RATE,
  parameter int PISO_OUTPUT_RATE = `ABR_PISO_OUTPUT_RATE
) (
  input  logic                        clk,
  input  logic                        rst_b,
  input  logic                        zeroize,
  // block side
  input  logic                        valid_i,
  output logic                        hold_o,
  input  logic [PISO_INPUT_RATE-1:0]  data_i,
  // word side
  output logic                        valid_o,
  input  logic                        hold_i,
  output logic [PISO_OUTPUT_RATE-1:0] data_o
);

  // pointer must reach the full buffer width
  localparam int PTR_W = $clog2(PISO_BUFFER_W + 1);

  localparam logic [PTR_W-1:0] IN_STEP   = PTR_W'(PISO_INPUT_RATE);
  localparam logic [PTR_W-1:0] OUT_STEP  = PTR_W'(PISO_OUTPUT_RATE);
  localparam logic [PTR_W-1:0] HOLD_MARK = PTR_W'(PISO_BUFFER_W - PISO_INPUT_RATE);

  logic [PISO_BUFFER_W-1:0] buffer;
  logic [PISO_BUFFER_W-1:0] buffer_d;
  logic [PISO_BUFFER_W-1:0] shifted;
  logic [PISO_BUFFER_W-1:0] data_ext;
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         wr_ptr_d;
  logic [PTR_W-1:0]         wr_pos;
  logic                     buf_wr;
  logic                     buf_rd;

  // not enough room left for a whole block
  assign hold_o  = wr_ptr > HOLD_MARK;

  // lowest bits go out first
  assign data_o  = buffer[PISO_OUTPUT_RATE-1:0];
  assign valid_o = wr_ptr >= OUT_STEP;

  assign buf_wr = valid_i & ~hold_o;
  assign buf_rd = valid_o & ~hold_i;

  assign data_ext = PISO_BUFFER_W'(data_i);

  always_comb begin
    // drop the word being read
    shifted = buf_rd ? (buffer >> PISO_OUTPUT_RATE) : buffer;
    // new block lands right above the remaining bits
    wr_pos  = buf_rd ? (wr_ptr - OUT_STEP) : wr_ptr;
    if (buf_wr) begin
      buffer_d = shifted | (data_ext << wr_pos);
      wr_ptr_d = wr_pos + IN_STEP;
    end else begin
      buffer_d = shifted;
      wr_ptr_d = wr_pos;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buffer <= '0;
      wr_ptr <= '0;
    end else if (zeroize) begin
      // leftover bits of a finished run are discarded
      buffer <= '0;
      wr_ptr <= '0;
    end else begin
      buffer <= buffer_d;
      wr_ptr <= wr_ptr_d;
    end
  end

  // fill level stays within the buffer
  a_ptr_bound : assert property (@(posedge clk) disable iff (!rst_b)
    wr_ptr <= PTR_W'(PISO_BUFFER_W));

  // while holding, the fill level can only drop
  a_no_wr_on_hold : assert property (@(posedge clk) disable iff (!rst_b)
    hold_o |=> wr_ptr <= $past(wr_ptr));

endmodule

//--- hdl/abr_rej_sampler.sv
/*
 * abr_rej_sampler
 * rejection sampler, splits each buffer word into candidates and
 * checks one per cycle against the modulus
 * accepted candidates leave as a one cycle coefficient strobe
 */

`timescale 1ns/1ps

`include "abr_sampler_cfg.svh"

module abr_rej_sampler (
  input  logic                 clk,
  input  logic                 rst_b,
  input  logic                 zeroize_i,
  input  logic                 run_i,
  // word link from the buffer
  input  logic                 word_valid_i,
  output logic                 word_hold_o,
  input  abr_data_pkg::word_t  word_data_i,
  // coefficient strobe
  output logic                 coeff_valid_o,
  output abr_data_pkg::coeff_t coeff_o
);

  localparam int CAND_W  = `ABR_CAND_W;
  localparam int LEFT_W  = $clog2(`ABR_CAND_PER_WORD + 1);

  localparam logic [LEFT_W-1:0]  ALL_CANDS = LEFT_W'(`ABR_CAND_PER_WORD);
  localparam abr_data_pkg::cand_t REJ_Q    = abr_data_pkg::cand_t'(`ABR_REJ_Q);

  // word under evaluation, current candidate always in the low bits
  abr_data_pkg::word_t word_q;
  logic [LEFT_W-1:0]   cand_left;
  abr_data_pkg::cand_t cand;
  logic                word_load;
  logic                cand_eval;
  logic                cand_ok;

  // next word may load on the edge that ends the last candidate
  assign word_hold_o = ~run_i | (cand_left > LEFT_W'(1));
  assign word_load   = word_valid_i & ~word_hold_o;

  // evaluation pauses while run is low
  assign cand_eval = run_i & (cand_left != '0);

  assign cand    = word_q[CAND_W-1:0];
  assign cand_ok = cand < REJ_Q;

  // strobe in the cycle of evaluation
  assign coeff_valid_o = cand_eval & cand_ok;
  assign coeff_o       = cand;

  // candidate counter
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cand_left <= '0;
    end else if (zeroize_i) begin
      cand_left <= '0;
    end else if (word_load) begin
      cand_left <= ALL_CANDS;
    end else if (cand_eval) begin
      cand_left <= cand_left - LEFT_W'(1);
    end
  end

  // word payload, shifted one candidate per evaluation
  always_ff @(posedge clk) begin
    if (word_load) begin
      word_q <= word_data_i;
    end else if (cand_eval) begin
      word_q <= word_q >> CAND_W;
    end
  end

  // accepted values are in range and only appear during a run
  a_coeff_below_q : assert property (@(posedge clk) disable iff (!rst_b)
    coeff_valid_o |-> (coeff_o < REJ_Q) && run_i);

endmodule

//--- hdl/abr_sampler_ctrl.sv
/*
 * abr_sampler_ctrl
 * run controller, starts a run on a start pulse, counts accepted
 * coefficients and ends the run after the last one
 * done and zeroize follow the end of a run by one cycle
 */

`timescale 1ns/1ps

`include "abr_sampler_cfg.svh"

module abr_sampler_ctrl (
  input  logic                     clk,
  input  logic                     rst_b,
  input  logic                     start_i,
  input  logic                     coeff_valid_i,
  output logic                     run_o,
  output logic                     zeroize_o,
  output logic                     done_o,
  output abr_data_pkg::coeff_idx_t coeff_idx_o
);

  localparam abr_data_pkg::coeff_idx_t LAST_IDX =
    abr_data_pkg::coeff_idx_t'(`ABR_NUM_COEFF - 1);

  abr_ctrl_pkg::ctrl_state_e state_q;
  abr_ctrl_pkg::ctrl_state_e state_d;
  abr_data_pkg::coeff_idx_t  cnt_q;
  logic                      run_q;
  logic                      done_q;
  logic                      last_accept;

  // final coefficient of the run
  assign last_accept = (state_q == abr_ctrl_pkg::RUN) & coeff_valid_i & (cnt_q == LAST_IDX);

  always_comb begin
    state_d = state_q;
    case (state_q)
      abr_ctrl_pkg::IDLE: begin
        if (start_i) begin
          state_d = abr_ctrl_pkg::RUN;
        end
      end
      abr_ctrl_pkg::RUN: begin
        // start is not looked at here
        if (last_accept) begin
          state_d = abr_ctrl_pkg::IDLE;
        end
      end
      default: state_d = abr_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= abr_ctrl_pkg::IDLE;
      cnt_q   <= '0;
      run_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // run drops on the same edge as the state
      run_q   <= (state_d == abr_ctrl_pkg::RUN);
      done_q  <= last_accept;
      if (state_q == abr_ctrl_pkg::IDLE && start_i) begin
        cnt_q <= '0;
      end else if (state_q == abr_ctrl_pkg::RUN && coeff_valid_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign run_o       = run_q;
  // one register feeds done and zeroize
  assign done_o      = done_q;
  assign zeroize_o   = done_q;
  // index of the coefficient in flight, before increment
  assign coeff_idx_o = cnt_q;

  // single cycle done pulse
  a_done_pulse : assert property (@(posedge clk) disable iff (!rst_b)
    done_o |=> !done_o);

  // start during a run neither restarts nor clears the count
  a_start_ignored : assert property (@(posedge clk) disable iff (!rst_b)
    (state_q == abr_ctrl_pkg::RUN) && start_i && !coeff_valid_i |=>
      (state_q == abr_ctrl_pkg::RUN) && (cnt_q == $past(cnt_q)));

endmodule

//--- hdl/abr_sampler_top.sv
/*
 * abr_sampler_top
 * coefficient sampler front end, blocks from the hash engine go
 * through the shift buffer into the rejection sampler, the
 * controller frames each run of coefficients
 */

`timescale 1ns/1ps

`include "abr_sampler_cfg.svh"

module abr_sampler_top (
  input  logic                     clk,
  input  logic                     rst_b,
  input  logic                     start_i,
  // block input
  input  logic                     blk_valid_i,
  output logic                     blk_hold_o,
  input  abr_data_pkg::blk_t       blk_data_i,
  // coefficient output
  output logic                     coeff_valid_o,
  output abr_data_pkg::coeff_t     coeff_o,
  output abr_data_pkg::coeff_idx_t coeff_idx_o,
  output logic                     done_o
);

  // word link
  logic                word_valid;
  logic                word_hold;
  abr_data_pkg::word_t word_data;

  // control
  logic                run;
  logic                zeroize;

  abr_piso #(
    .PISO_BUFFER_W    (`ABR_PISO_BUFFER_W),
    .PISO_INPUT_RATE  (`ABR_PISO_INPUT_RATE),
    .PISO_OUTPUT_RATE (`ABR_PISO_OUTPUT_RATE)
  ) u_piso (
    .clk     (clk),
    .rst_b   (rst_b),
    .zeroize (zeroize),
    .valid_i (blk_valid_i),
    .hold_o  (blk_hold_o),
    .data_i  (blk_data_i),
    .valid_o (word_valid),
    .hold_i  (word_hold),
    .data_o  (word_data)
  );

  abr_rej_sampler u_rej_sampler (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize),
    .run_i         (run),
    .word_valid_i  (word_valid),
    .word_hold_o   (word_hold),
    .word_data_i   (word_data),
    .coeff_valid_o (coeff_valid_o),
    .coeff_o       (coeff_o)
  );

  // counts the strobe leaving the top
  abr_sampler_ctrl u_ctrl (
    .clk           (clk),
    .rst_b         (rst_b),
    .start_i       (start_i),
    .coeff_valid_i (coeff_valid_o),
    .run_o         (run),
    .zeroize_o     (zeroize),
    .done_o        (done_o),
    .coeff_idx_o   (coeff_idx_o)
  );

endmodule

//--- tests/abr_sampler_tb.sv
/*
 * abr_sampler_tb
 * testbench for the coefficient sampler front end
 * random rate blocks go in, a bit-level model of the buffer and
 * the rejection rule predicts every coefficient of three runs
 */

`timescale 1ns/1ps

`include "abr_sampler_cfg.svh"

module abr_sampler_tb;

  localparam int NUM_RUNS  = 3;
  localparam int NUM_COEFF = `ABR_NUM_COEFF;
  localparam int BLK_W     = `ABR_PISO_INPUT_RATE;
  localparam int WORD_W    = `ABR_PISO_OUTPUT_RATE;
  localparam int CAND_W    = `ABR_CAND_W;
  localparam int CAND_N    = `ABR_CAND_PER_WORD;
  localparam int Q         = `ABR_REJ_Q;
  // one block feeds about 55 cycles of candidate evaluation
  localparam int CYC_PER_BLK = 80;
  localparam int WD_MARGIN   = 500;

  logic                     clk;
  logic                     rst_b;
  logic                     start_i;
  logic                     blk_valid_i;
  logic                     blk_hold_o;
  abr_data_pkg::blk_t       blk_data_i;
  logic                     coeff_valid_o;
  abr_data_pkg::coeff_t     coeff_o;
  abr_data_pkg::coeff_idx_t coeff_idx_o;
  logic                     done_o;

  integer seed;
  int     err_cnt;
  int     wd_cycles;
  int     blk_base;

  // model output, blocks of all runs back to back
  abr_data_pkg::blk_t   blk_q[$];
  abr_data_pkg::coeff_t kept_q[$];
  int                   run_blks[NUM_RUNS];

  abr_sampler_top dut (
    .clk           (clk),
    .rst_b         (rst_b),
    .start_i       (start_i),
    .blk_valid_i   (blk_valid_i),
    .blk_hold_o    (blk_hold_o),
    .blk_data_i    (blk_data_i),
    .coeff_valid_o (coeff_valid_o),
    .coeff_o       (coeff_o),
    .coeff_idx_o   (coeff_idx_o),
    .done_o        (done_o)
  );

  always #50 clk = ~clk;

  task automatic stop_on_error(input string msg);
    err_cnt++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  // random blocks per run, stream cut LSB first into words and candidates
  task automatic build_models();
    logic [2047:0]       pend;
    int                  pend_n;
    int                  kept_n;
    abr_data_pkg::blk_t  blk;
    abr_data_pkg::word_t word;
    abr_data_pkg::cand_t cand;
    for (int r = 0; r < NUM_RUNS; r++) begin
      // each run starts from an empty stream
      pend        = '0;
      pend_n      = 0;
      kept_n      = 0;
      run_blks[r] = 0;
      while (kept_n < NUM_COEFF) begin
        for (int i = 0; i < BLK_W / 32; i++) begin
          blk[i*32 +: 32] = $random(seed);
        end
        blk_q.push_back(blk);
        run_blks[r]++;
        pend   = pend | (2048'(blk) << pend_n);
        pend_n = pend_n + BLK_W;
        // only complete words reach the sampler
        while (pend_n >= WORD_W) begin
          word   = pend[WORD_W-1:0];
          pend   = pend >> WORD_W;
          pend_n = pend_n - WORD_W;
          for (int c = 0; c < CAND_N; c++) begin
            cand = word[c*CAND_W +: CAND_W];
            if (cand < Q && kept_n < NUM_COEFF) begin
              kept_q.push_back(cand);
              kept_n++;
            end
          end
        end
      end
    end
  endtask

  // offers blocks in order, holds them until taken, random idle gaps
  task automatic drive_blocks(input int first, input int count);
    int   sent;
    int   gap;
    logic taken;
    sent = 0;
    while (sent < count) begin
      blk_valid_i = 1'b1;
      blk_data_i  = blk_q[first + sent];
      taken       = 1'b0;
      while (!taken) begin
        // hold is registered, stable at the falling edge
        @(negedge clk);
        taken = !blk_hold_o;
        @(posedge clk);
        #1;
      end
      sent++;
      blk_valid_i = 1'b0;
      blk_data_i  = {34{32'hdead_beef}};
      gap = {$random(seed)} % 4;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // compares each strobe with the model, then the done pulse
  task automatic check_run(input int r);
    int                   idx;
    logic                 done_due;
    logic                 seen_done;
    abr_data_pkg::coeff_t exp;
    idx       = 0;
    done_due  = 1'b0;
    seen_done = 1'b0;
    while (!seen_done) begin
      @(negedge clk);
      assert (done_o == done_due) else
        stop_on_error($sformatf("run %0d: done_o %0b, expected %0b after %0d coefficients",
                                r, done_o, done_due, idx));
      seen_done = done_o;
      done_due  = 1'b0;
      if (coeff_valid_o) begin
        assert (idx < NUM_COEFF) else
          stop_on_error($sformatf("run %0d: coefficient beyond the last one", r));
        exp = kept_q[r*NUM_COEFF + idx];
        assert (coeff_o == exp) else
          stop_on_error($sformatf("run %0d coeff %0d: got %0d, expected %0d",
                                  r, idx, coeff_o, exp));
        assert (coeff_idx_o == abr_data_pkg::coeff_idx_t'(idx)) else
          stop_on_error($sformatf("run %0d: coeff_idx_o %0d, expected %0d",
                                  r, coeff_idx_o, idx));
        idx++;
        done_due = (idx == NUM_COEFF);
      end
    end
    // nothing more until the next start, buffer emptied by zeroize
    repeat (6) begin
      @(negedge clk);
      assert (!coeff_valid_o && !done_o && !blk_hold_o) else
        stop_on_error($sformatf("run %0d: activity after done", r));
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_b       = 1'b0;
    start_i     = 1'b0;
    blk_valid_i = 1'b0;
    blk_data_i  = '0;
    seed        = 58;
    err_cnt     = 0;
    wd_cycles   = 0;
    blk_base    = 0;
    build_models();
    wd_cycles = blk_q.size() * CYC_PER_BLK + WD_MARGIN;
    repeat (10) @(posedge clk);
    #1;
    rst_b = 1'b1;
    // quiet before the first start
    repeat (10) begin
      @(negedge clk);
      assert (!coeff_valid_o && !done_o && !blk_hold_o) else
        stop_on_error("outputs active before start");
    end
    @(posedge clk);
    #1;
    for (int r = 0; r < NUM_RUNS; r++) begin
      start_i = 1'b1;
      @(posedge clk);
      #1;
      start_i = 1'b0;
      fork
        drive_blocks(blk_base, run_blks[r]);
        check_run(r);
      join
      blk_base = blk_base + run_blks[r];
      @(posedge clk);
      #1;
    end
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // budget follows the number of blocks the model needs
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the runs did not finish", wd_cycles);
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  end

endmodule
